/* build.f */
mem_net_pkg.sv
ring_router.sv
ring_net.sv
mem_net_adapter.sv
mem_net.sv
tb_bank_model.sv
tb_mem_net.sv

/* Makefile */
# memory network simulation with Verilator

VERILATOR   ?= verilator
FILELIST    ?= build.f
TOP         ?= tb_mem_net
SINGLE_BANK ?= 0
OBJ_DIR     ?= obj_dir_sb$(SINGLE_BANK)
VFLAGS      ?= --timing --assert
PASS_TEXT   ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  -Gsingle_bank=$(SINGLE_BANK)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
	  -Gsingle_bank=$(SINGLE_BANK) -Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf obj_dir obj_dir_sb0 obj_dir_sb1 $(OBJ_DIR)

/* tb_mem_net.sv */
//==========================================================================
// memory network testbench
// random traffic from four ports to four bank models, checked per pair
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module tb_mem_net
  import mem_net_pkg::*;
#(
  parameter bit single_bank = 1'b0
);

  localparam int          num_reqs   = 400;
  localparam int          clk_period = 8;
  localparam int          num_pairs  = num_ports * num_ports;
  localparam logic [31:0] fill_key   = 32'h5a3c_c3a5;

  logic clk = 1'b0;
  logic rst_n;

  mem_req_t  [num_ports-1:0] req_in_msg;
  logic      [num_ports-1:0] req_in_valid;
  logic      [num_ports-1:0] req_in_ready;
  mem_req_t  [num_ports-1:0] req_out_msg;
  logic      [num_ports-1:0] req_out_valid;
  wire       [num_ports-1:0] req_out_ready;
  wire mem_resp_t [num_ports-1:0] resp_in_msg;
  wire       [num_ports-1:0] resp_in_valid;
  logic      [num_ports-1:0] resp_in_ready;
  mem_resp_t [num_ports-1:0] resp_out_msg;
  logic      [num_ports-1:0] resp_out_valid;
  logic      [num_ports-1:0] resp_out_ready;
  logic      [num_ports-1:0] stall;

  // expectations per pair indexed by port * num_ports + bank
  mem_req_t   req_q  [num_pairs][$];
  mem_resp_t  resp_q [num_pairs][$];
  logic [3:0] seq    [num_pairs];

  // reference memory indexed by {bank, addr[9:6]}
  logic [31:0] ref_mem [64];
  logic [63:0] ref_written = '0;

  logic [31:0] lfsr_state = 32'd32575;
  int          fail_count = 0;
  int          made_count = 0;
  int          resp_count = 0;
  logic        started    = 1'b0;

  always #(clk_period / 2) clk = ~clk;

  mem_net #(
    .single_bank (single_bank)
  ) mem_net_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_in_msg     (req_in_msg),
    .req_in_valid   (req_in_valid),
    .req_in_ready   (req_in_ready),
    .req_out_msg    (req_out_msg),
    .req_out_valid  (req_out_valid),
    .req_out_ready  (req_out_ready),
    .resp_in_msg    (resp_in_msg),
    .resp_in_valid  (resp_in_valid),
    .resp_in_ready  (resp_in_ready),
    .resp_out_msg   (resp_out_msg),
    .resp_out_valid (resp_out_valid),
    .resp_out_ready (resp_out_ready)
  );

  for (genvar b = 0; b < num_ports; b++) begin : g_bank
    tb_bank_model #(
      .fill_key (fill_key)
    ) bank_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .stall      (stall[b]),
      .req_msg    (req_out_msg[b]),
      .req_valid  (req_out_valid[b]),
      .req_ready  (req_out_ready[b]),
      .resp_msg   (resp_in_msg[b]),
      .resp_valid (resp_in_valid[b]),
      .resp_ready (resp_in_ready[b])
    );
  end

  //========================================================================
  // random numbers and reference functions
  //========================================================================

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      r = {r[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return r;
  endfunction

  // consecutive 16-byte lines go to consecutive banks
  function automatic port_idx_t exp_bank(logic [31:0] addr);
    if (single_bank) begin
      return '0;
    end else begin
      return port_idx_t'((addr / 32'd16) % num_ports);
    end
  endfunction

  // source port goes into the top opaque bits
  function automatic logic [7:0] exp_opaque(logic [7:0] opaque, port_idx_t port);
    return {port, opaque[tag_lsb-1:0]};
  endfunction

  //========================================================================
  // checking tasks
  //========================================================================

  task automatic check_val(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      fail_count++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stop_with_error(string why);
    fail_count++;
    $display("error: %s", why);
    $display("Test FAILED");
    $fatal(1, "%s", why);
  endtask

  // address holds the port in 9:8, the word in 7:6, the bank in 5:4 and the offset in 3:0
  task automatic make_request(int p);
    mem_req_t    m;
    port_idx_t   bank;
    logic [31:0] r;
    logic [1:0]  idx;
    logic [1:0]  bsel;
    logic [3:0]  off;
    logic [1:0]  top;
    int          k;
    r       = rand_bits(1);
    m.mtype = r[0] ? mem_write : mem_read;
    r       = rand_bits(2);
    idx     = r[1:0];
    r       = rand_bits(2);
    bsel    = r[1:0];
    r       = rand_bits(4);
    off     = r[3:0];
    m.addr  = {22'h0, port_idx_t'(p), idx, bsel, off};
    m.data  = rand_bits(32);
    r       = rand_bits(2);
    top     = r[1:0];
    bank    = exp_bank(m.addr);
    k       = p * num_ports + int'(bank);
    // low opaque bits carry the bank and a per-pair sequence number
    m.opaque = {top, bank, seq[k]};
    seq[k]   = seq[k] + 4'd1;
    req_in_msg[p] = m;
  endtask

  task automatic record_issue(int p);
    mem_req_t   m;
    mem_resp_t  r;
    port_idx_t  bank;
    logic [5:0] loc;
    int         k;
    m        = req_in_msg[p];
    bank     = exp_bank(m.addr);
    k        = p * num_ports + int'(bank);
    m.opaque = exp_opaque(m.opaque, port_idx_t'(p));
    req_q[k].push_back(m);
    loc      = {bank, m.addr[9:6]};
    r.mtype  = m.mtype;
    r.opaque = m.opaque;
    if (m.mtype == mem_write) begin
      r.data           = '0;
      ref_mem[loc]     = m.data;
      ref_written[loc] = 1'b1;
    end else if (ref_written[loc]) begin
      r.data = ref_mem[loc];
    end else begin
      r.data = m.addr ^ fill_key;
    end
    resp_q[k].push_back(r);
  endtask

  //========================================================================
  // stimulus
  //========================================================================

  initial begin : drive_traffic
    logic [num_ports-1:0] took;
    logic [31:0]          r;
    rst_n          = 1'b0;
    req_in_msg     = '0;
    req_in_valid   = '0;
    resp_out_ready = '0;
    stall          = '1;
    for (int k = 0; k < num_pairs; k++) begin
      seq[k] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // outputs must stay quiet over a few idle cycles
    repeat (4) @(posedge clk);
    while (resp_count < num_reqs) begin
      @(posedge clk);
      took = req_in_valid & req_in_ready;
      #1;
      for (int p = 0; p < num_ports; p++) begin
        if (took[p]) begin
          record_issue(p);
          req_in_valid[p] = 1'b0;
        end
        r = rand_bits(1);
        if (!req_in_valid[p] && made_count < num_reqs && r[0]) begin
          make_request(p);
          req_in_valid[p] = 1'b1;
          made_count++;
          started = 1'b1;
        end
        r                 = rand_bits(2);
        stall[p]          = (r[1:0] == 2'd0);
        r                 = rand_bits(2);
        resp_out_ready[p] = (r[1:0] != 2'd0);
      end
    end
    // every ready stays open so stray or duplicated messages show up
    stall          = '0;
    resp_out_ready = '1;
    repeat (40) @(posedge clk);
    #1;
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  //========================================================================
  // output comparison
  //========================================================================

  always @(posedge clk) begin : compare_outputs
    mem_req_t  exp_req;
    mem_resp_t exp_resp;
    port_idx_t tag;
    int        k;
    if (rst_n) begin
      if (!started) begin
        check_val("req_out_valid", 128'(req_out_valid), 128'(0));
        check_val("resp_out_valid", 128'(resp_out_valid), 128'(0));
      end
      if (single_bank) begin
        check_val("req_out_valid[3:1]", 128'(req_out_valid[num_ports-1:1]), 128'(0));
      end
      for (int b = 0; b < num_ports; b++) begin
        if (req_out_valid[b] && req_out_ready[b]) begin
          tag = req_out_msg[b].opaque[tag_lsb +: srcdest_nbits];
          k   = int'(tag) * num_ports + b;
          if (req_q[k].size() == 0) begin
            stop_with_error($sformatf("bank %0d got a request from port %0d never issued",
                                      b, tag));
          end else begin
            exp_req = req_q[k].pop_front();
            check_val($sformatf("req_out_msg[%0d].mtype", b),
                      128'(req_out_msg[b].mtype), 128'(exp_req.mtype));
            check_val($sformatf("req_out_msg[%0d].addr", b),
                      128'(req_out_msg[b].addr), 128'(exp_req.addr));
            check_val($sformatf("req_out_msg[%0d].data", b),
                      128'(req_out_msg[b].data), 128'(exp_req.data));
            check_val($sformatf("req_out_msg[%0d].opaque", b),
                      128'(req_out_msg[b].opaque), 128'(exp_req.opaque));
          end
        end
      end
      for (int p = 0; p < num_ports; p++) begin
        if (resp_out_valid[p] && resp_out_ready[p]) begin
          // bank index rides in opaque bits 5:4
          tag = resp_out_msg[p].opaque[5:4];
          k   = p * num_ports + int'(tag);
          if (resp_q[k].size() == 0) begin
            stop_with_error($sformatf("port %0d got a response from bank %0d never expected",
                                      p, tag));
          end else begin
            exp_resp = resp_q[k].pop_front();
            check_val($sformatf("resp_out_msg[%0d].mtype", p),
                      128'(resp_out_msg[p].mtype), 128'(exp_resp.mtype));
            check_val($sformatf("resp_out_msg[%0d].opaque", p),
                      128'(resp_out_msg[p].opaque), 128'(exp_resp.opaque));
            check_val($sformatf("resp_out_msg[%0d].data", p),
                      128'(resp_out_msg[p].data), 128'(exp_resp.data));
            resp_count++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(num_reqs * 40 * clk_period);
    $display("timeout: %0d of %0d responses came back", resp_count, num_reqs);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* tb_bank_model.sv */
//==========================================================================
// testbench memory bank
// answers one request at a time, ready is stalled by the testbench
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module tb_bank_model
  import mem_net_pkg::*;
#(
  parameter logic [31:0] fill_key = 32'h0
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      stall,
  input  mem_req_t  req_msg,
  input  logic      req_valid,
  output logic      req_ready,
  output mem_resp_t resp_msg,
  output logic      resp_valid,
  input  logic      resp_ready
);

  // 16 words, location is address bits 9:6
  logic [31:0] mem [16];
  logic [15:0] written;
  logic        take_req;
  logic        take_resp;
  mem_req_t    req_hold;
  logic [3:0]  loc;

  // at most one response outstanding
  assign req_ready = !stall && !resp_valid;

  initial begin
    resp_valid = 1'b0;
    resp_msg   = '0;
    written    = '0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid = 1'b0;
      resp_msg   = '0;
      written    = '0;
    end else begin
      take_req  = req_valid && req_ready;
      take_resp = resp_valid && resp_ready;
      req_hold  = req_msg;
      #1;
      if (take_resp) begin
        resp_valid = 1'b0;
      end
      if (take_req) begin
        loc             = req_hold.addr[9:6];
        resp_msg.mtype  = req_hold.mtype;
        resp_msg.opaque = req_hold.opaque;
        if (req_hold.mtype == mem_write) begin
          mem[loc]      = req_hold.data;
          written[loc]  = 1'b1;
          resp_msg.data = '0;
        end else if (written[loc]) begin
          resp_msg.data = mem[loc];
        end else begin
          // never written, answer with a pattern of the whole address
          resp_msg.data = req_hold.addr ^ fill_key;
        end
        resp_valid = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* mem_net.sv */
//==========================================================================
// memory network
// request and response rings joined by per-port adapters into one network
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module mem_net
  import mem_net_pkg::*;
#(
  parameter bit single_bank = 1'b0
) (
  input  logic                      clk,
  input  logic                      rst_n,

  // processor requests
  input  mem_req_t  [num_ports-1:0] req_in_msg,
  input  logic      [num_ports-1:0] req_in_valid,
  output logic      [num_ports-1:0] req_in_ready,

  // requests toward the banks
  output mem_req_t  [num_ports-1:0] req_out_msg,
  output logic      [num_ports-1:0] req_out_valid,
  input  logic      [num_ports-1:0] req_out_ready,

  // bank responses
  input  mem_resp_t [num_ports-1:0] resp_in_msg,
  input  logic      [num_ports-1:0] resp_in_valid,
  output logic      [num_ports-1:0] resp_in_ready,

  // responses toward the processors
  output mem_resp_t [num_ports-1:0] resp_out_msg,
  output logic      [num_ports-1:0] resp_out_valid,
  input  logic      [num_ports-1:0] resp_out_ready
);

  req_net_msg_t  [num_ports-1:0] req_net_in_msg;
  req_net_msg_t  [num_ports-1:0] req_net_out_msg;
  logic          [num_ports-1:0] req_net_out_valid;
  logic          [num_ports-1:0] req_net_out_ready;

  resp_net_msg_t [num_ports-1:0] resp_net_in_msg;
  logic          [num_ports-1:0] resp_net_in_valid;
  resp_net_msg_t [num_ports-1:0] resp_net_out_msg;

  // one adapter per port serves both rings
  for (genvar i = 0; i < num_ports; i++) begin : g_port
    mem_net_adapter #(
      .port_id     (i),
      .single_bank (single_bank)
    ) adapter_i (
      .req_in_msg        (req_in_msg[i]),
      .req_net_msg       (req_net_in_msg[i]),
      .req_net_out       (req_net_out_msg[i]),
      .req_out_msg       (req_out_msg[i]),
      .req_out_valid_net (req_net_out_valid[i]),
      .req_out_valid     (req_out_valid[i]),
      .req_out_ready     (req_out_ready[i]),
      .req_out_ready_net (req_net_out_ready[i]),
      .resp_in_msg       (resp_in_msg[i]),
      .resp_in_valid     (resp_in_valid[i]),
      .resp_in_valid_net (resp_net_in_valid[i]),
      .resp_net_msg      (resp_net_in_msg[i]),
      .resp_net_out      (resp_net_out_msg[i]),
      .resp_out_msg      (resp_out_msg[i])
    );
  end

  //========================================================================
  // rings
  //========================================================================

  ring_net #(
    .msg_t (req_net_msg_t)
  ) req_ring (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_msg    (req_net_in_msg),
    .in_valid  (req_in_valid),
    .in_ready  (req_in_ready),
    .out_msg   (req_net_out_msg),
    .out_valid (req_net_out_valid),
    .out_ready (req_net_out_ready)
  );

  // responses travel independently, so a stalled bank cannot block requests
  ring_net #(
    .msg_t (resp_net_msg_t)
  ) resp_ring (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_msg    (resp_net_in_msg),
    .in_valid  (resp_net_in_valid),
    .in_ready  (resp_in_ready),
    .out_msg   (resp_net_out_msg),
    .out_valid (resp_out_valid),
    .out_ready (resp_out_ready)
  );

endmodule

`default_nettype wire

/* mem_net_adapter.sv */
//==========================================================================
// memory network adapter
// converts memory messages to and from network messages for one port
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module mem_net_adapter
  import mem_net_pkg::*;
#(
  parameter int port_id     = 0,
  parameter bit single_bank = 1'b0
) (
  // processor request into the request ring
  input  mem_req_t      req_in_msg,
  output req_net_msg_t  req_net_msg,

  // request ring out to the bank
  input  req_net_msg_t  req_net_out,
  output mem_req_t      req_out_msg,
  input  logic          req_out_valid_net,
  output logic          req_out_valid,
  input  logic          req_out_ready,
  output logic          req_out_ready_net,

  // bank response into the response ring
  input  mem_resp_t     resp_in_msg,
  input  logic          resp_in_valid,
  output logic          resp_in_valid_net,
  output resp_net_msg_t resp_net_msg,

  // response ring out to the processor
  input  resp_net_msg_t resp_net_out,
  output mem_resp_t     resp_out_msg
);

  localparam port_idx_t my_id = srcdest_nbits'(port_id);

  // in single-bank mode only bank 0 stays attached
  localparam bit bank_live = !single_bank || (port_id == 0);

  port_idx_t req_dest;
  port_idx_t resp_tag;

  //========================================================================
  // request path
  //========================================================================

  assign req_dest = single_bank ? '0 : req_in_msg.addr[bank_sel_lsb +: srcdest_nbits];

  always_comb begin
    req_net_msg.dest    = req_dest;
    req_net_msg.src     = my_id;
    req_net_msg.opaque  = '0;
    req_net_msg.payload = req_in_msg;
    // source port replaces the top opaque bits, the bank echoes them back
    req_net_msg.payload.opaque[tag_lsb +: srcdest_nbits] = my_id;
  end

  assign req_out_msg       = req_net_out.payload;
  assign req_out_valid     = req_out_valid_net && bank_live;
  assign req_out_ready_net = req_out_ready && bank_live;

  //========================================================================
  // response path
  //========================================================================

  assign resp_tag = resp_in_msg.opaque[tag_lsb +: srcdest_nbits];

  always_comb begin
    resp_net_msg.dest    = resp_tag;
    resp_net_msg.src     = my_id;
    resp_net_msg.opaque  = '0;
    resp_net_msg.payload = resp_in_msg;
  end

  assign resp_in_valid_net = resp_in_valid && bank_live;
  assign resp_out_msg      = resp_net_out.payload;

  // a cut-off bank never gets a request, so it has nothing to answer
  always_comb begin
    if (resp_in_valid) begin
      assert (int'(resp_tag) < num_ports && bank_live)
        else $error("adapter %0d: response tag %0d from a detached bank",
                    port_id, resp_tag);
    end
  end

endmodule

`default_nettype wire

/* ring_net.sv */
//==========================================================================
// ring network
// unidirectional ring of routers with one inject/eject channel per port
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module ring_net
  import mem_net_pkg::*;
#(
  parameter type msg_t = req_net_msg_t
) (
  input  logic                 clk,
  input  logic                 rst_n,

  // injection channels
  input  msg_t [num_ports-1:0] in_msg,
  input  logic [num_ports-1:0] in_valid,
  output logic [num_ports-1:0] in_ready,

  // ejection channels
  output msg_t [num_ports-1:0] out_msg,
  output logic [num_ports-1:0] out_valid,
  input  logic [num_ports-1:0] out_ready
);

  // link k runs from router k to router k+1
  msg_t link_msg   [num_ports];
  logic link_valid [num_ports];
  logic link_ready [num_ports];

  for (genvar k = 0; k < num_ports; k++) begin : g_node

    // upstream neighbour of this node
    localparam int prev = (k + num_ports - 1) % num_ports;

    ring_router #(
      .msg_t   (msg_t),
      .node_id (k)
    ) router_i (
      .clk            (clk),
      .rst_n          (rst_n),

      .ring_in_msg    (link_msg[prev]),
      .ring_in_valid  (link_valid[prev]),
      .ring_in_ready  (link_ready[prev]),

      .inj_msg        (in_msg[k]),
      .inj_valid      (in_valid[k]),
      .inj_ready      (in_ready[k]),

      .ring_out_msg   (link_msg[k]),
      .ring_out_valid (link_valid[k]),
      .ring_out_ready (link_ready[k]),

      .ej_msg         (out_msg[k]),
      .ej_valid       (out_valid[k]),
      .ej_ready       (out_ready[k])
    );

  end

endmodule

`default_nettype wire

/* ring_router.sv */
//==========================================================================
// ring router
// one ring node with a two-entry buffer on the forward and ejection outputs
//==========================================================================

`timescale 1ns/100ps
`default_nettype none

module ring_router
  import mem_net_pkg::*;
#(
  parameter type msg_t   = req_net_msg_t,
  parameter int  node_id = 0
) (
  input  logic clk,
  input  logic rst_n,

  // link from the upstream router
  input  msg_t ring_in_msg,
  input  logic ring_in_valid,
  output logic ring_in_ready,

  // local injection
  input  msg_t inj_msg,
  input  logic inj_valid,
  output logic inj_ready,

  // link to the downstream router
  output msg_t ring_out_msg,
  output logic ring_out_valid,
  input  logic ring_out_ready,

  // local ejection
  output msg_t ej_msg,
  output logic ej_valid,
  input  logic ej_ready
);

  // buffer 0 feeds ring_out, buffer 1 feeds ej
  localparam int fwd_buf = 0;
  localparam int ej_buf  = 1;

  localparam port_idx_t my_id = srcdest_nbits'(node_id);

  msg_t       slot     [2][2];
  logic [1:0] count    [2];
  logic       has_room [2];
  logic       push     [2];
  logic       pop      [2];
  msg_t       push_msg [2];

  // target buffer index is 1 when the message stops here
  logic ring_tgt;
  logic inj_tgt;
  logic inj_space;
  logic ring_take;
  logic inj_take;

  //========================================================================
  // steering and arbitration
  //========================================================================

  assign ring_tgt = (ring_in_msg.dest == my_id);
  assign inj_tgt  = (inj_msg.dest == my_id);

  // ready never looks at the output side, so no path runs around the ring
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      has_room[b] = (count[b] != 2'd2);
    end
  end

  assign ring_in_ready = has_room[ring_tgt];

  // injection into the forward buffer leaves a free slot behind, so the ring never fills up
  assign inj_space = inj_tgt ? has_room[ej_buf] : (count[fwd_buf] == 2'd0);

  // ring traffic keeps the buffer when both inputs want it
  assign inj_ready = inj_space && !(ring_in_valid && (ring_tgt == inj_tgt));

  assign ring_take = ring_in_valid && ring_in_ready;
  assign inj_take  = inj_valid && inj_ready;

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      push[b]     = (ring_take && (int'(ring_tgt) == b)) ||
                    (inj_take && (int'(inj_tgt) == b));
      push_msg[b] = (ring_take && (int'(ring_tgt) == b)) ? ring_in_msg : inj_msg;
    end
  end

  //========================================================================
  // output buffers
  //========================================================================

  assign ring_out_msg   = slot[fwd_buf][0];
  assign ring_out_valid = (count[fwd_buf] != 2'd0);
  assign ej_msg         = slot[ej_buf][0];
  assign ej_valid       = (count[ej_buf] != 2'd0);

  assign pop[fwd_buf] = ring_out_valid && ring_out_ready;
  assign pop[ej_buf]  = ej_valid && ej_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < 2; b++) begin
        count[b] <= 2'd0;
      end
    end else begin
      for (int b = 0; b < 2; b++) begin
        case ({push[b], pop[b]})
          2'b10:   count[b] <= count[b] + 2'd1;
          2'b01:   count[b] <= count[b] - 2'd1;
          default: count[b] <= count[b];
        endcase
      end
    end
  end

  // slot 0 is the head and a push that meets a pop goes straight there
  always_ff @(posedge clk) begin
    for (int b = 0; b < 2; b++) begin
      if (pop[b] && !push[b]) begin
        slot[b][0] <= slot[b][1];
      end else if (push[b] && (pop[b] || count[b] == 2'd0)) begin
        slot[b][0] <= push_msg[b];
      end else if (push[b]) begin
        slot[b][1] <= push_msg[b];
      end
    end
  end

  //========================================================================
  // checks
  //========================================================================

  a_ring_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ring_out_valid && !ring_out_ready |=> ring_out_valid && $stable(ring_out_msg));

  a_ej_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ej_valid && !ej_ready |=> ej_valid && $stable(ej_msg));

  // a message for this node must never go round again
  a_no_pass_home: assert property (@(posedge clk) disable iff (!rst_n)
    ring_out_valid |-> ring_out_msg.dest != my_id);

endmodule

`default_nettype wire

/* mem_net_pkg.sv */
//==========================================================================
// memory network package
// memory and network message formats shared by the rings and the adapters
//==========================================================================

`default_nettype none

package mem_net_pkg;

  //========================================================================
  // sizes
  //========================================================================

  // processor ports and cache banks are paired one to one
  localparam int num_ports        = 4;
  localparam int srcdest_nbits    = $clog2(num_ports);
  localparam int net_opaque_nbits = 4;

  localparam int mem_opaque_nbits = 8;
  localparam int mem_addr_nbits   = 32;
  localparam int mem_data_nbits   = 32;

  // banks interleave on 16-byte lines
  localparam int bank_sel_lsb = 4;

  // the source port rides in the top bits of the memory opaque
  localparam int tag_lsb = mem_opaque_nbits - srcdest_nbits;

  typedef logic [srcdest_nbits-1:0] port_idx_t;

  //========================================================================
  // memory messages
  //========================================================================

  typedef enum logic [0:0] {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_e;

  // 73 bits
  typedef struct packed {
    mem_type_e                   mtype;
    logic [mem_opaque_nbits-1:0] opaque;
    logic [mem_addr_nbits-1:0]   addr;
    logic [mem_data_nbits-1:0]   data;
  } mem_req_t;

  // 41 bits
  typedef struct packed {
    mem_type_e                   mtype;
    logic [mem_opaque_nbits-1:0] opaque;
    logic [mem_data_nbits-1:0]   data;
  } mem_resp_t;

  //========================================================================
  // network messages
  //========================================================================

  // dest sits in the top bits, the routers only look at that field
  typedef struct packed {
    port_idx_t                   dest;
    port_idx_t                   src;
    logic [net_opaque_nbits-1:0] opaque;
    mem_req_t                    payload;
  } req_net_msg_t;

  typedef struct packed {
    port_idx_t                   dest;
    port_idx_t                   src;
    logic [net_opaque_nbits-1:0] opaque;
    mem_resp_t                   payload;
  } resp_net_msg_t;

endpackage

`default_nettype wire
